// ==== gaussian_blur.f ====
gaussian_blur_pkg.sv
blur_bus_if.sv
blur_wb_master.sv
blur_line_buffer.sv
blur_kernel_3x3.sv
blur_ctrl.sv
gaussian_blur_top.sv
tb_clock_gen.sv
tb_gaussian_blur.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_gaussian_blur
FILELIST  ?= gaussian_blur.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

# Rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); exit $$status
	@if grep -q "TESTBENCH FAILED" $(LOG); then echo "Simulation failed"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== tb_gaussian_blur.sv ====
`timescale 1ns/10ps

module tb_gaussian_blur;

  localparam int img_w = 16;
  localparam int img_h = 8;
  localparam logic [15:0] in_base  = 16'h0000;
  localparam logic [15:0] out_base = 16'h1000;
  localparam int n_pix = img_w * img_h;

  localparam logic [1:0] kind_const  = 2'd0;
  localparam logic [1:0] kind_ramp   = 2'd1;
  localparam logic [1:0] kind_random = 2'd2;

  // Worst case is about 6.5 cycles per access with 3 wait states
  localparam int n_cases = 6;
  localparam int cycles_per_access = 8;
  localparam int cycle_limit = n_cases * (cycles_per_access * 2 * n_pix + 50) + 20;

  typedef struct packed {
    logic [1:0] kind;
    logic [7:0] value;
    logic [7:0] exp_corner;
    logic [7:0] exp_edge;
    logic [7:0] exp_inner;
  } case_t;

  logic        clk;
  logic        rst_n;
  logic        start;
  logic        busy;
  logic        done;
  logic        wb_cyc;
  logic        wb_stb;
  logic        wb_we;
  logic [15:0] wb_adr;
  logic [7:0]  wb_dat_o;
  logic [7:0]  wb_dat_i;
  logic        wb_ack;

  logic [7:0]  mem [0:65535];
  bit          written [n_pix];
  case_t       cases [n_cases];
  integer      seed = 32'h3966_8e8a;
  int          errors;
  int          mismatches;
  int          checks;
  int          done_count;
  int          write_count;
  int          read_count;
  int          cycle_count;
  int          wait_left;
  bit          in_cycle;
  logic [15:0] hold_adr;
  logic        hold_we;
  logic [7:0]  hold_dat;

  tb_clock_gen #(.period_ns(4.0)) i_clock_gen (.clk(clk));

  gaussian_blur_top #(
    .img_w    (img_w),
    .img_h    (img_h),
    .in_base  (in_base),
    .out_base (out_base)
  ) i_dut (
    .clk      (clk),
    .rst_n    (rst_n),
    .start    (start),
    .busy     (busy),
    .done     (done),
    .wb_cyc   (wb_cyc),
    .wb_stb   (wb_stb),
    .wb_we    (wb_we),
    .wb_adr   (wb_adr),
    .wb_dat_o (wb_dat_o),
    .wb_dat_i (wb_dat_i),
    .wb_ack   (wb_ack)
  );

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    checks = checks + 1;
    if (got !== exp) begin
      mismatches = mismatches + 1;
      $display("MISMATCH at %0t: %s got %0d expected %0d", $time, name, got, exp);
    end
  endtask

  function automatic logic [7:0] fill_pattern(input int a);
    return 8'(a) ^ 8'(a >> 8) ^ 8'hc3;
  endfunction

  function automatic bit in_out_region(input logic [15:0] a);
    return (int'(a) >= int'(out_base)) && (int'(a) < int'(out_base) + n_pix);
  endfunction

  // 1-2-1 in both directions, zero outside the image, round to nearest
  function automatic int ref_pixel(input int r, input int c);
    int sum;
    int dr;
    int dc;
    int w;
    sum = 0;
    for (dr = -1; dr <= 1; dr++) begin
      for (dc = -1; dc <= 1; dc++) begin
        if (r + dr >= 0 && r + dr < img_h && c + dc >= 0 && c + dc < img_w) begin
          w = ((dr == 0) ? 2 : 1) * ((dc == 0) ? 2 : 1);
          sum = sum + w * int'(mem[int'(in_base) + (r + dr) * img_w + c + dc]);
        end
      end
    end
    return (sum + 8) >> 4;
  endfunction

  task automatic fill_image(input logic [1:0] kind, input logic [7:0] value);
    int r;
    int c;
    int a;
    for (r = 0; r < img_h; r++) begin
      for (c = 0; c < img_w; c++) begin
        a = int'(in_base) + r * img_w + c;
        case (kind)
          kind_const: mem[a] = value;
          kind_ramp:  mem[a] = 8'(int'(value) + c * 16);
          default:    mem[a] = 8'($random(seed));
        endcase
      end
    end
    // Old results must not survive into the next check
    for (a = 0; a < n_pix; a++) begin
      mem[int'(out_base) + a] = fill_pattern(int'(out_base) + a);
      written[a] = 1'b0;
    end
  endtask

  task automatic run_case(input int n, input case_t tc);
    int r;
    int c;
    int got;
    logic [7:0] exp_pos;
    fill_image(tc.kind, tc.value);
    done_count  = 0;
    write_count = 0;
    read_count  = 0;
    @(posedge clk);
    #1 start = 1'b1;
    @(posedge clk);
    #1 start = 1'b0;
    check_value("busy", 32'(busy), 32'd1);
    while (done_count == 0) begin
      @(posedge clk);
    end
    repeat (3) @(posedge clk);
    #1;
    check_value("done pulses", 32'(done_count), 32'd1);
    check_value("busy", 32'(busy), 32'd0);
    check_value("write count", 32'(write_count), 32'(n_pix));
    check_value("read count", 32'(read_count), 32'(n_pix));
    for (r = 0; r < img_h; r++) begin
      for (c = 0; c < img_w; c++) begin
        got = int'(mem[int'(out_base) + r * img_w + c]);
        check_value($sformatf("case %0d out[%0d][%0d]", n, r, c), 32'(got),
                    32'(ref_pixel(r, c)));
        if (tc.kind == kind_const) begin
          if ((r == 0 || r == img_h - 1) && (c == 0 || c == img_w - 1)) begin
            exp_pos = tc.exp_corner;
          end else if (r == 0 || r == img_h - 1 || c == 0 || c == img_w - 1) begin
            exp_pos = tc.exp_edge;
          end else begin
            exp_pos = tc.exp_inner;
          end
          check_value($sformatf("case %0d table[%0d][%0d]", n, r, c), 32'(got),
                      32'(exp_pos));
        end
      end
    end
  endtask

  // Wishbone slave with random wait states, plus bus protocol checks
  initial begin
    wb_ack   = 1'b0;
    wb_dat_i = 8'h00;
    in_cycle = 1'b0;
    forever begin
      @(posedge clk);
      #1;
      if (wb_stb && !wb_cyc) begin
        errors = errors + 1;
        $display("ERROR at %0t: stb is high while cyc is low", $time);
      end
      if (done) begin
        done_count = done_count + 1;
        if (busy) begin
          errors = errors + 1;
          $display("ERROR at %0t: busy still high in the done cycle", $time);
        end
      end
      if (wb_ack) begin
        wb_ack   = 1'b0;
        in_cycle = 1'b0;
        if (wb_cyc) begin
          errors = errors + 1;
          $display("ERROR at %0t: cyc did not drop after ack", $time);
        end
      end else if (wb_cyc && wb_stb) begin
        if (!in_cycle) begin
          in_cycle  = 1'b1;
          hold_adr  = wb_adr;
          hold_we   = wb_we;
          hold_dat  = wb_dat_o;
          wait_left = $unsigned($random(seed)) % 4;
        end else begin
          check_value("wb_adr", 32'(wb_adr), 32'(hold_adr));
          check_value("wb_we", 32'(wb_we), 32'(hold_we));
          if (hold_we) check_value("wb_dat_o", 32'(wb_dat_o), 32'(hold_dat));
        end
        if (wait_left == 0) begin
          wb_ack = 1'b1;
          if (wb_we) begin
            if (!in_out_region(wb_adr)) begin
              errors = errors + 1;
              $display("ERROR at %0t: write to %h outside the output region", $time, wb_adr);
            end else begin
              if (written[int'(wb_adr) - int'(out_base)]) begin
                errors = errors + 1;
                $display("ERROR at %0t: second write to %h", $time, wb_adr);
              end
              written[int'(wb_adr) - int'(out_base)] = 1'b1;
            end
            write_count = write_count + 1;
            mem[wb_adr] = wb_dat_o;
          end else begin
            if (in_out_region(wb_adr)) begin
              errors = errors + 1;
              $display("ERROR at %0t: read from %h inside the output region", $time, wb_adr);
            end
            read_count = read_count + 1;
            wb_dat_i   = mem[wb_adr];
          end
        end else begin
          wait_left = wait_left - 1;
        end
      end
    end
  end

  initial begin
    cycle_count = 0;
    while (cycle_count <= cycle_limit) begin
      @(posedge clk);
      cycle_count = cycle_count + 1;
    end
    $display("Timeout after %0d cycles, the image sweep did not finish", cycle_count);
    $display("TESTBENCH FAILED");
    $finish;
  end

  initial begin
    int a;
    int i;
    rst_n = 1'b0;
    start = 1'b0;
    errors = 0;
    mismatches = 0;
    checks = 0;
    for (a = 0; a < 65536; a++) begin
      mem[a] = fill_pattern(a);
    end
    cases[0] = '{kind_const,  8'd255, 8'd143, 8'd191, 8'd255};
    cases[1] = '{kind_const,  8'd0,   8'd0,   8'd0,   8'd0};
    cases[2] = '{kind_ramp,   8'd3,   8'd0,   8'd0,   8'd0};
    cases[3] = '{kind_random, 8'd0,   8'd0,   8'd0,   8'd0};
    cases[4] = '{kind_const,  8'd255, 8'd143, 8'd191, 8'd255};
    cases[5] = '{kind_random, 8'd0,   8'd0,   8'd0,   8'd0};
    repeat (3) @(posedge clk);
    #1 rst_n = 1'b1;
    check_value("busy", 32'(busy), 32'd0);
    check_value("done", 32'(done), 32'd0);
    check_value("wb_cyc", 32'(wb_cyc), 32'd0);
    for (i = 0; i < n_cases; i++) begin
      run_case(i, cases[i]);
    end
    $display("Checks: %0d, mismatches: %0d, other errors: %0d", checks, mismatches, errors);
    if (mismatches == 0 && errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

// ==== tb_clock_gen.sv ====
`timescale 1ns/10ps

module tb_clock_gen #(
  parameter real period_ns = 4.0
) (
  output logic clk
);

  initial begin
    clk = 1'b0;
  end

  always begin
    #(period_ns / 2.0);
    clk = ~clk;
  end

endmodule

// ==== gaussian_blur_top.sv ====
`timescale 1ns/10ps

module gaussian_blur_top #(
  parameter int                       img_w    = 16,
  parameter int                       img_h    = 8,
  parameter gaussian_blur_pkg::addr_t in_base  = 16'h0000,
  parameter gaussian_blur_pkg::addr_t out_base = 16'h1000
) (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      start,
  output logic                      busy,
  output logic                      done,
  output logic                      wb_cyc,
  output logic                      wb_stb,
  output logic                      wb_we,
  output gaussian_blur_pkg::addr_t  wb_adr,
  output gaussian_blur_pkg::pixel_t wb_dat_o,
  input  gaussian_blur_pkg::pixel_t wb_dat_i,
  input  logic                      wb_ack
);
  import gaussian_blur_pkg::*;

  localparam int col_w = $clog2(img_w + 1);

  logic             pix_valid;
  logic             zero_row;
  logic             row_first;
  logic [col_w-1:0] col;
  pixel_t           pix_in;
  pixel_t           lb_top;
  pixel_t           lb_mid;
  pixel_t           lb_bot;
  logic             col_valid;
  pixel_t           out_pix;
  logic             out_valid;

  blur_bus_if bus_if ();

  blur_ctrl #(
    .img_w    (img_w),
    .img_h    (img_h),
    .in_base  (in_base),
    .out_base (out_base)
  ) i_ctrl (
    .clk       (clk),
    .rst_n     (rst_n),
    .start     (start),
    .busy      (busy),
    .done      (done),
    .bus       (bus_if.ctrl),
    .pix_valid (pix_valid),
    .zero_row  (zero_row),
    .row_first (row_first),
    .col       (col),
    .pix_in    (pix_in),
    .out_pix   (out_pix),
    .out_valid (out_valid)
  );

  blur_wb_master i_wb_master (
    .clk      (clk),
    .rst_n    (rst_n),
    .bus      (bus_if.master),
    .wb_cyc   (wb_cyc),
    .wb_stb   (wb_stb),
    .wb_we    (wb_we),
    .wb_adr   (wb_adr),
    .wb_dat_o (wb_dat_o),
    .wb_dat_i (wb_dat_i),
    .wb_ack   (wb_ack)
  );

  blur_line_buffer #(
    .img_w (img_w)
  ) i_line_buffer (
    .clk       (clk),
    .rst_n     (rst_n),
    .pix_valid (pix_valid),
    .zero_row  (zero_row),
    .row_first (row_first),
    .col       (col),
    .pix_in    (pix_in),
    .top       (lb_top),
    .mid       (lb_mid),
    .bot       (lb_bot),
    .col_valid (col_valid)
  );

  blur_kernel_3x3 #(
    .img_w (img_w),
    .img_h (img_h)
  ) i_kernel (
    .clk       (clk),
    .rst_n     (rst_n),
    .col_valid (col_valid),
    .top       (lb_top),
    .mid       (lb_mid),
    .bot       (lb_bot),
    .out_pix   (out_pix),
    .out_valid (out_valid)
  );

endmodule

// ==== blur_ctrl.sv ====
`timescale 1ns/10ps

module blur_ctrl #(
  parameter int                       img_w    = 16,
  parameter int                       img_h    = 8,
  parameter gaussian_blur_pkg::addr_t in_base  = 16'h0000,
  parameter gaussian_blur_pkg::addr_t out_base = 16'h1000
) (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       start,
  output logic                       busy,
  output logic                       done,
  blur_bus_if.ctrl                   bus,
  output logic                       pix_valid,
  output logic                       zero_row,
  output logic                       row_first,
  output logic [$clog2(img_w+1)-1:0] col,
  output gaussian_blur_pkg::pixel_t  pix_in,
  input  gaussian_blur_pkg::pixel_t  out_pix,
  input  logic                       out_valid
);
  import gaussian_blur_pkg::*;

  localparam int col_w = $clog2(img_w + 1);
  localparam int row_w = $clog2(img_h + 1);
  localparam logic [col_w-1:0] last_col     = col_w'(img_w);
  localparam logic [row_w-1:0] last_row     = row_w'(img_h);
  localparam logic [col_w-1:0] last_out_col = col_w'(img_w - 1);
  localparam logic [row_w-1:0] last_out_row = row_w'(img_h - 1);

  localparam logic [2:0] st_idle       = 3'd0;
  localparam logic [2:0] st_read       = 3'd1;
  localparam logic [2:0] st_wait_read  = 3'd2;
  localparam logic [2:0] st_feed       = 3'd3;
  localparam logic [2:0] st_write      = 3'd4;
  localparam logic [2:0] st_wait_write = 3'd5;
  localparam logic [2:0] st_finish     = 3'd6;

  logic [2:0]       state;
  logic [row_w-1:0] in_row;
  logic [col_w-1:0] in_col;
  logic [row_w-1:0] nxt_row;
  logic [col_w-1:0] nxt_col;
  logic [row_w-1:0] out_row;
  logic [col_w-1:0] out_col;
  logic             nxt_real;
  logic             has_out;
  logic             last_out;
  logic             res_ok;
  logic             req_open;
  pixel_t           pix_reg;
  pixel_t           res_reg;
  addr_t            rd_adr;
  addr_t            wr_adr;

  // Next sweep position, and whether it needs a bus read
  always_comb begin
    if (in_col == last_col) begin
      nxt_col = '0;
      nxt_row = in_row + 1'b1;
    end else begin
      nxt_col = in_col + 1'b1;
      nxt_row = in_row;
    end
    nxt_real = (nxt_row != last_row) && (nxt_col != last_col);
  end

  assign has_out  = (in_row != '0) && (in_col != '0);
  assign last_out = (out_row == last_out_row) && (out_col == last_out_col);
  assign rd_adr   = addr_t'(in_base + in_row * img_w + in_col);
  assign wr_adr   = addr_t'(out_base + out_row * img_w + out_col);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state   <= st_idle;
      in_row  <= '0;
      in_col  <= '0;
      out_row <= '0;
      out_col <= '0;
    end else begin
      case (state)
        st_idle: begin
          if (start) begin
            in_row  <= '0;
            in_col  <= '0;
            out_row <= '0;
            out_col <= '0;
            state   <= st_read;
          end
        end
        st_read:
          state <= st_wait_read;
        st_wait_read:
          if (bus.ack) state <= st_feed;
        st_feed: begin
          if (has_out) begin
            state <= st_write;
          end else begin
            in_row <= nxt_row;
            in_col <= nxt_col;
            state  <= nxt_real ? st_read : st_feed;
          end
        end
        // Waits here for the kernel result of the column just fed
        st_write:
          if (res_ok) state <= st_wait_write;
        st_wait_write: begin
          if (bus.ack) begin
            if (out_col == last_out_col) begin
              out_col <= '0;
              out_row <= out_row + 1'b1;
            end else begin
              out_col <= out_col + 1'b1;
            end
            if (last_out) begin
              state <= st_finish;
            end else begin
              in_row <= nxt_row;
              in_col <= nxt_col;
              state  <= nxt_real ? st_read : st_feed;
            end
          end
        end
        st_finish:
          state <= st_idle;
        default:
          state <= st_idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      res_ok   <= 1'b0;
      req_open <= 1'b0;
    end else begin
      if (out_valid) begin
        res_ok <= 1'b1;
      end else if (state == st_wait_write && bus.ack) begin
        res_ok <= 1'b0;
      end
      if (bus.req) begin
        req_open <= 1'b1;
      end else if (bus.ack) begin
        req_open <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (state == st_wait_read && bus.ack) pix_reg <= bus.rdat;
    if (out_valid) res_reg <= out_pix;
  end

  assign busy      = (state != st_idle) && (state != st_finish);
  assign done      = (state == st_finish);
  assign pix_valid = (state == st_feed);
  assign zero_row  = (in_row == last_row);
  assign row_first = (in_row == '0);
  assign col       = in_col;
  // Stale in padding positions, the line buffer zeroes those
  assign pix_in    = pix_reg;

  assign bus.req  = (state == st_read) || (state == st_write && res_ok);
  assign bus.we   = (state == st_write);
  assign bus.adr  = (state == st_write) ? wr_adr : rd_adr;
  assign bus.wdat = res_reg;

  a_one_outstanding: assert property (
    @(posedge clk) disable iff (!rst_n)
    bus.req |-> !req_open
  );

endmodule

// ==== blur_kernel_3x3.sv ====
`timescale 1ns/10ps

module blur_kernel_3x3 #(
  parameter int img_w = 16,
  parameter int img_h = 8
) (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      col_valid,
  input  gaussian_blur_pkg::pixel_t top,
  input  gaussian_blur_pkg::pixel_t mid,
  input  gaussian_blur_pkg::pixel_t bot,
  output gaussian_blur_pkg::pixel_t out_pix,
  output logic                      out_valid
);
  import gaussian_blur_pkg::*;

  localparam int col_w = $clog2(img_w + 1);
  localparam int row_w = $clog2(img_h + 1);
  localparam logic [col_w-1:0] flush_col = col_w'(img_w);
  localparam logic [row_w-1:0] last_row  = row_w'(img_h);

  logic [col_w-1:0] kcol;
  logic [row_w-1:0] krow;
  pixel_t           left_col [3];
  pixel_t           ctr_col  [3];
  logic [acc_w-1:0] sum;

  function automatic logic [acc_w-1:0] tap3(
    input pixel_t           a,
    input pixel_t           b,
    input pixel_t           c,
    input logic [acc_w-1:0] w_side,
    input logic [acc_w-1:0] w_mid
  );
    return acc_w'(a) * w_side + acc_w'(b) * w_mid + acc_w'(c) * w_side;
  endfunction

  // Incoming triple is the right column of the window
  assign sum = tap3(left_col[0], ctr_col[0], top, k_corner, k_edge)
             + tap3(left_col[1], ctr_col[1], mid, k_edge, k_center)
             + tap3(left_col[2], ctr_col[2], bot, k_corner, k_edge);

  // Own position in the sweep, img_w + 1 columns by img_h + 1 rows
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      kcol      <= '0;
      krow      <= '0;
      out_valid <= 1'b0;
    end else begin
      out_valid <= col_valid && (kcol != '0) && (krow != '0);
      if (col_valid) begin
        if (kcol == flush_col) begin
          kcol <= '0;
          krow <= (krow == last_row) ? '0 : krow + 1'b1;
        end else begin
          kcol <= kcol + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (col_valid) begin
      // Left padding at the start of each row
      left_col[0] <= (kcol == '0) ? '0 : ctr_col[0];
      left_col[1] <= (kcol == '0) ? '0 : ctr_col[1];
      left_col[2] <= (kcol == '0) ? '0 : ctr_col[2];
      ctr_col[0]  <= top;
      ctr_col[1]  <= mid;
      ctr_col[2]  <= bot;
      out_pix     <= blur_round(sum);
    end
  end

endmodule

// ==== blur_line_buffer.sv ====
`timescale 1ns/10ps

module blur_line_buffer #(
  parameter int img_w = 16
) (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      pix_valid,
  input  logic                      zero_row,
  input  logic                      row_first,
  input  logic [$clog2(img_w+1)-1:0] col,
  input  gaussian_blur_pkg::pixel_t pix_in,
  output gaussian_blur_pkg::pixel_t top,
  output gaussian_blur_pkg::pixel_t mid,
  output gaussian_blur_pkg::pixel_t bot,
  output logic                      col_valid
);
  import gaussian_blur_pkg::*;

  localparam int col_w = $clog2(img_w + 1);
  localparam int idx_w = (img_w > 1) ? $clog2(img_w) : 1;
  localparam logic [col_w-1:0] flush_col = col_w'(img_w);

  pixel_t           row_old  [img_w];
  pixel_t           row_prev [img_w];
  logic [1:0]       rows_held;
  logic [1:0]       rows_now;
  logic             flush;
  logic [idx_w-1:0] idx;
  pixel_t           pix_eff;

  assign flush    = (col == flush_col);
  assign idx      = idx_w'(col);
  // Rows left over from the previous image are masked off
  assign rows_now = row_first ? 2'd0 : rows_held;
  assign pix_eff  = (zero_row || flush) ? '0 : pix_in;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rows_held <= 2'd0;
      col_valid <= 1'b0;
    end else begin
      col_valid <= pix_valid;
      if (pix_valid && flush) begin
        rows_held <= (rows_now == 2'd2) ? 2'd2 : rows_now + 2'd1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (pix_valid) begin
      if (flush) begin
        // Right-hand padding column
        top <= '0;
        mid <= '0;
        bot <= '0;
      end else begin
        top <= (rows_now == 2'd2) ? row_old[idx] : '0;
        mid <= (rows_now != 2'd0) ? row_prev[idx] : '0;
        bot <= pix_eff;
        row_old[idx]  <= row_prev[idx];
        row_prev[idx] <= pix_eff;
      end
    end
  end

  a_col_range: assert property (
    @(posedge clk) disable iff (!rst_n)
    pix_valid |-> col <= flush_col
  );

endmodule

// ==== blur_wb_master.sv ====
`timescale 1ns/10ps

module blur_wb_master (
  input  logic                      clk,
  input  logic                      rst_n,
  blur_bus_if.master                bus,
  output logic                      wb_cyc,
  output logic                      wb_stb,
  output logic                      wb_we,
  output gaussian_blur_pkg::addr_t  wb_adr,
  output gaussian_blur_pkg::pixel_t wb_dat_o,
  input  gaussian_blur_pkg::pixel_t wb_dat_i,
  input  logic                      wb_ack
);
  import gaussian_blur_pkg::*;

  logic   cyc_q;
  logic   we_q;
  addr_t  adr_q;
  pixel_t dat_q;

  // Cycle opens the edge after req, closes the edge after ack
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      cyc_q <= 1'b0;
      we_q  <= 1'b0;
    end else begin
      if (cyc_q && wb_ack) begin
        cyc_q <= 1'b0;
      end else if (bus.req) begin
        cyc_q <= 1'b1;
      end
      if (bus.req) begin
        we_q <= bus.we;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (bus.req) begin
      adr_q <= bus.adr;
      dat_q <= bus.wdat;
    end
  end

  assign wb_cyc   = cyc_q;
  assign wb_stb   = cyc_q;
  assign wb_we    = we_q;
  assign wb_adr   = adr_q;
  assign wb_dat_o = dat_q;

  // Read data is only meaningful in the ack cycle
  assign bus.ack  = cyc_q && wb_ack;
  assign bus.rdat = wb_dat_i;

  // Request must not move while the slave stretches the cycle
  a_req_stable: assert property (
    @(posedge clk) disable iff (!rst_n)
    wb_stb && !wb_ack |=> $stable(wb_adr) && $stable(wb_we) && $stable(wb_dat_o)
  );

endmodule

// ==== blur_bus_if.sv ====
`timescale 1ns/10ps

interface blur_bus_if;
  import gaussian_blur_pkg::*;

  logic   req;
  logic   we;
  addr_t  adr;
  pixel_t wdat;
  logic   ack;
  pixel_t rdat;

  modport ctrl (
    output req,
    output we,
    output adr,
    output wdat,
    input  ack,
    input  rdat
  );

  modport master (
    input  req,
    input  we,
    input  adr,
    input  wdat,
    output ack,
    output rdat
  );

endinterface

// ==== gaussian_blur_pkg.sv ====
package gaussian_blur_pkg;

  localparam int pix_w = 8;
  typedef logic [pix_w-1:0] pixel_t;

  // Holds 16 * 255 + bias without overflow
  localparam int acc_w = 12;

  localparam int round_shift = 4;
  localparam logic [acc_w-1:0] round_bias = 12'd8;

  localparam int adr_w = 16;
  typedef logic [adr_w-1:0] addr_t;

  // Separable 1-2-1 weights, corner / edge / center of the 3x3 kernel
  localparam logic [acc_w-1:0] k_corner = 12'd1;
  localparam logic [acc_w-1:0] k_edge   = 12'd2;
  localparam logic [acc_w-1:0] k_center = 12'd4;

  // Round to nearest, weights sum to 16
  function automatic pixel_t blur_round(input logic [acc_w-1:0] sum);
    logic [acc_w-1:0] biased;
    biased = sum + round_bias;
    return pixel_t'(biased >> round_shift);
  endfunction

endpackage
